//--- hdl/nts_api.sv
/*
 * Pipelined address decoder for the NTS register interface.
 * Four stages: capture, region decode, endpoint read capture, and
 * response mux. Every request returns one valid pulse 3 edges later.
 */

module nts_api #(
  parameter nts_api_pkg::api_addr_t ADDR_ENGINE_BASE = 12'h000,
  parameter nts_api_pkg::api_addr_t ADDR_ENGINE_STOP = 12'h009,
  parameter nts_api_pkg::api_addr_t ADDR_CLOCK_BASE  = 12'h010,
  parameter nts_api_pkg::api_addr_t ADDR_CLOCK_STOP  = 12'h01F,
  parameter nts_api_pkg::api_addr_t ADDR_KEYMEM_BASE = 12'h080,
  parameter nts_api_pkg::api_addr_t ADDR_KEYMEM_STOP = 12'h17F
) (
  input  logic                  i_clk,
  input  logic                  i_areset,
  output logic                  o_busy,

  input  logic                  i_api_cs,
  input  nts_api_pkg::ext_req_t i_api_req,
  output nts_api_pkg::api_data_t o_api_read_data,
  output logic                  o_api_read_data_valid,

  output nts_api_pkg::int_req_t o_int_req,
  output logic                  o_engine_cs,
  output logic                  o_clock_cs,
  output logic                  o_keymem_cs,
  input  nts_api_pkg::api_data_t i_engine_read_data,
  input  nts_api_pkg::api_data_t i_clock_read_data,
  input  nts_api_pkg::api_data_t i_keymem_read_data
);

  import nts_api_pkg::*;

  // One flag per endpoint region
  typedef struct packed {
    logic engine;
    logic clock;
    logic keymem;
  } sel_t;

  logic      busy_reg;

  // Stage 0, raw host request
  logic      p0_cs_reg;
  ext_req_t  p0_req_reg;

  // Stage 1, decoded request on the internal bus
  logic      p1_cs_reg;
  sel_t      p1_sel_reg;
  int_req_t  p1_req_reg;

  // Stage 2, endpoint words
  logic      p2_cs_reg;
  logic      p2_we_reg;
  sel_t      p2_sel_reg;
  api_data_t p2_engine_data_reg;
  api_data_t p2_clock_data_reg;
  api_data_t p2_keymem_data_reg;

  // Stage 3, response
  api_data_t p3_read_data_reg;
  logic      p3_valid_reg;

  // Decode helpers
  sel_t      sel;
  int_addr_t addr_offset;
  api_data_t p3_read_data_new;

  assign o_int_req             = p1_req_reg;
  assign o_engine_cs           = p1_sel_reg.engine;
  assign o_clock_cs            = p1_sel_reg.clock;
  assign o_keymem_cs           = p1_sel_reg.keymem;
  assign o_busy                = busy_reg;
  assign o_api_read_data       = p3_read_data_reg;
  assign o_api_read_data_valid = p3_valid_reg;

  // Inclusive range check on a word address
  function automatic logic in_region(api_addr_t addr, api_addr_t base, api_addr_t stop);
    return (addr >= base) && (addr <= stop);
  endfunction

  //--------------------------------------------------------------------
  // Address decode, reads stage 0
  //--------------------------------------------------------------------

  always_comb begin : address_decode
    api_addr_t base;
    api_addr_t diff;
    sel  = '0;
    base = '0;
    // First matching region wins
    if (in_region(p0_req_reg.address, ADDR_ENGINE_BASE, ADDR_ENGINE_STOP)) begin
      sel.engine = 1'b1;
      base       = ADDR_ENGINE_BASE;
    end else if (in_region(p0_req_reg.address, ADDR_CLOCK_BASE, ADDR_CLOCK_STOP)) begin
      sel.clock = 1'b1;
      base      = ADDR_CLOCK_BASE;
    end else if (in_region(p0_req_reg.address, ADDR_KEYMEM_BASE, ADDR_KEYMEM_STOP)) begin
      sel.keymem = 1'b1;
      base       = ADDR_KEYMEM_BASE;
    end
    diff = p0_req_reg.address - base;
    // Offset wider than the internal bus folds to zero
    if (diff[11:8] != 4'h0) begin
      addr_offset = '0;
    end else begin
      addr_offset = diff[7:0];
    end
  end

  //--------------------------------------------------------------------
  // Response mux, reads stage 2
  //--------------------------------------------------------------------

  always_comb begin
    p3_read_data_new = '0;
    // Writes and unmapped reads answer with zero
    if (p2_cs_reg && !p2_we_reg) begin
      if (p2_sel_reg.engine) begin
        p3_read_data_new = p2_engine_data_reg;
      end else if (p2_sel_reg.clock) begin
        p3_read_data_new = p2_clock_data_reg;
      end else if (p2_sel_reg.keymem) begin
        p3_read_data_new = p2_keymem_data_reg;
      end
    end
  end

  //--------------------------------------------------------------------
  // Pipeline control
  //--------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      busy_reg     <= 1'b0;
      p0_cs_reg    <= 1'b0;
      p1_cs_reg    <= 1'b0;
      p1_sel_reg   <= '0;
      p2_cs_reg    <= 1'b0;
      p2_we_reg    <= 1'b0;
      p2_sel_reg   <= '0;
      p3_valid_reg <= 1'b0;
    end else begin
      // A request reaching stage 2 clears busy, ahead of a new strobe
      if (p2_cs_reg) begin
        busy_reg <= 1'b0;
      end else if (i_api_cs) begin
        busy_reg <= 1'b1;
      end
      p0_cs_reg    <= i_api_cs;
      p1_cs_reg    <= p0_cs_reg;
      p1_sel_reg   <= p0_cs_reg ? sel : '0;
      p2_cs_reg    <= p1_cs_reg;
      p2_we_reg    <= p1_req_reg.we;
      p2_sel_reg   <= p1_sel_reg;
      p3_valid_reg <= p2_cs_reg;
    end
  end

  // Payload stages
  always_ff @(posedge i_clk) begin
    p0_req_reg         <= i_api_req;
    p1_req_reg         <= '{we: p0_req_reg.we, address: addr_offset,
                            write_data: p0_req_reg.write_data};
    p2_engine_data_reg <= i_engine_read_data;
    p2_clock_data_reg  <= i_clock_read_data;
    p2_keymem_data_reg <= i_keymem_read_data;
    p3_read_data_reg   <= p3_read_data_new;
  end

endmodule

//--- hdl/nts_api_pkg.sv
/*
 * Shared types and constants for the NTS engine register front end.
 * Host request and internal request formats, data widths and the
 * identity words reported by the engine register block.
 */

package nts_api_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------

  // Host word address
  typedef logic [11:0] api_addr_t;
  // Region-relative word address seen by the endpoints
  typedef logic [7:0]  int_addr_t;
  typedef logic [31:0] api_data_t;
  typedef logic [31:0] key_id_t;

  //--------------------------------------------------------------------
  // Requests
  //--------------------------------------------------------------------

  // One host request, qualified by the chip select strobe
  typedef struct packed {
    logic      we;
    api_addr_t address;
    api_data_t write_data;
  } ext_req_t;

  // Request after decode, shared by all endpoints
  typedef struct packed {
    logic      we;
    int_addr_t address;
    api_data_t write_data;
  } int_req_t;

  // Engine identity, ASCII "nts-" "engn" "0.01"
  localparam api_data_t ENGINE_NAME0   = 32'h6e74_732d;
  localparam api_data_t ENGINE_NAME1   = 32'h656e_676e;
  localparam api_data_t ENGINE_VERSION = 32'h302e_3031;

endpackage

//--- hdl/nts_api_top.sv
/*
 * Register front end top. Host bus decoder with the engine, clock
 * and key memory register blocks behind it.
 */

module nts_api_top #(
  parameter nts_api_pkg::api_addr_t ADDR_ENGINE_BASE = 12'h000,
  parameter nts_api_pkg::api_addr_t ADDR_ENGINE_STOP = 12'h009,
  parameter nts_api_pkg::api_addr_t ADDR_CLOCK_BASE  = 12'h010,
  parameter nts_api_pkg::api_addr_t ADDR_CLOCK_STOP  = 12'h01F,
  parameter nts_api_pkg::api_addr_t ADDR_KEYMEM_BASE = 12'h080,
  parameter nts_api_pkg::api_addr_t ADDR_KEYMEM_STOP = 12'h17F
) (
  input  logic                   i_clk,
  input  logic                   i_areset,
  input  logic                   i_api_cs,
  input  nts_api_pkg::ext_req_t  i_api_req,
  output logic                   o_busy,
  output nts_api_pkg::api_data_t o_api_read_data,
  output logic                   o_api_read_data_valid,
  output logic                   o_engine_enable,
  output logic                   o_key_valid,
  output nts_api_pkg::key_id_t   o_key_id
);

  import nts_api_pkg::*;

  // Internal bus
  int_req_t  int_req;
  logic      engine_cs;
  logic      clock_cs;
  logic      keymem_cs;
  api_data_t engine_read_data;
  api_data_t clock_read_data;
  api_data_t keymem_read_data;

  nts_api #(
    .ADDR_ENGINE_BASE (ADDR_ENGINE_BASE),
    .ADDR_ENGINE_STOP (ADDR_ENGINE_STOP),
    .ADDR_CLOCK_BASE  (ADDR_CLOCK_BASE),
    .ADDR_CLOCK_STOP  (ADDR_CLOCK_STOP),
    .ADDR_KEYMEM_BASE (ADDR_KEYMEM_BASE),
    .ADDR_KEYMEM_STOP (ADDR_KEYMEM_STOP)
  ) api0 (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .o_busy                (o_busy),
    .i_api_cs              (i_api_cs),
    .i_api_req             (i_api_req),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid),
    .o_int_req             (int_req),
    .o_engine_cs           (engine_cs),
    .o_clock_cs            (clock_cs),
    .o_keymem_cs           (keymem_cs),
    .i_engine_read_data    (engine_read_data),
    .i_clock_read_data     (clock_read_data),
    .i_keymem_read_data    (keymem_read_data)
  );

  nts_engine_regs engine0 (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_cs            (engine_cs),
    .i_req           (int_req),
    .o_read_data     (engine_read_data),
    .o_engine_enable (o_engine_enable)
  );

  nts_clock_regs clock0 (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_cs        (clock_cs),
    .i_req       (int_req),
    .o_read_data (clock_read_data)
  );

  nts_keymem keymem0 (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_cs        (keymem_cs),
    .i_req       (int_req),
    .o_read_data (keymem_read_data),
    .o_key_valid (o_key_valid),
    .o_key_id    (o_key_id)
  );

endmodule

//--- hdl/nts_clock_regs.sv
/*
 * Time counter block. A 64-bit counter with run control, loaded
 * from two staging words, and a snapshot latch for coherent reads.
 */

module nts_clock_regs (
  input  logic                   i_clk,
  input  logic                   i_areset,
  input  logic                   i_cs,
  input  nts_api_pkg::int_req_t  i_req,
  output nts_api_pkg::api_data_t o_read_data
);

  import nts_api_pkg::*;

  //--------------------------------------------------------------------
  // Register map
  //--------------------------------------------------------------------

  localparam int_addr_t ADDR_RUN      = 8'h00;
  localparam int_addr_t ADDR_LOAD_HI  = 8'h01;
  localparam int_addr_t ADDR_LOAD_LO  = 8'h02;
  localparam int_addr_t ADDR_LOAD     = 8'h03;
  localparam int_addr_t ADDR_LATCH    = 8'h04;
  localparam int_addr_t ADDR_SNAP_HI  = 8'h05;
  localparam int_addr_t ADDR_SNAP_LO  = 8'h06;

  logic        run_reg;
  api_data_t   load_hi_reg;
  api_data_t   load_lo_reg;
  logic [63:0] counter_reg;
  logic [63:0] snapshot_reg;
  logic        wr;

  assign wr = i_cs && i_req.we;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      run_reg      <= 1'b0;
      load_hi_reg  <= '0;
      load_lo_reg  <= '0;
      counter_reg  <= '0;
      snapshot_reg <= '0;
    end else begin
      if (wr && i_req.address == ADDR_RUN) begin
        run_reg <= i_req.write_data[0];
      end
      if (wr && i_req.address == ADDR_LOAD_HI) begin
        load_hi_reg <= i_req.write_data;
      end
      if (wr && i_req.address == ADDR_LOAD_LO) begin
        load_lo_reg <= i_req.write_data;
      end
      // Snapshot takes the value before this edge's increment
      if (wr && i_req.address == ADDR_LATCH) begin
        snapshot_reg <= counter_reg;
      end
      // Load wins over counting
      if (wr && i_req.address == ADDR_LOAD) begin
        counter_reg <= {load_hi_reg, load_lo_reg};
      end else if (run_reg) begin
        counter_reg <= counter_reg + 64'd1;
      end
    end
  end

  always_comb begin
    o_read_data = '0;
    if (i_cs) begin
      case (i_req.address)
        ADDR_RUN:     o_read_data = {31'd0, run_reg};
        ADDR_LOAD_HI: o_read_data = load_hi_reg;
        ADDR_LOAD_LO: o_read_data = load_lo_reg;
        ADDR_SNAP_HI: o_read_data = snapshot_reg[63:32];
        ADDR_SNAP_LO: o_read_data = snapshot_reg[31:0];
        default:      o_read_data = '0;
      endcase
    end
  end

endmodule

//--- hdl/nts_engine_regs.sv
/*
 * Engine register block. Identity words, a control register whose
 * bit 0 enables the engine, and a scratch register.
 */

module nts_engine_regs (
  input  logic                   i_clk,
  input  logic                   i_areset,
  input  logic                   i_cs,
  input  nts_api_pkg::int_req_t  i_req,
  output nts_api_pkg::api_data_t o_read_data,
  output logic                   o_engine_enable
);

  import nts_api_pkg::*;

  //--------------------------------------------------------------------
  // Register map
  //--------------------------------------------------------------------

  localparam int_addr_t ADDR_NAME0   = 8'h00;
  localparam int_addr_t ADDR_NAME1   = 8'h01;
  localparam int_addr_t ADDR_VERSION = 8'h02;
  localparam int_addr_t ADDR_CTRL    = 8'h08;
  localparam int_addr_t ADDR_SCRATCH = 8'h09;

  api_data_t ctrl_reg;
  api_data_t scratch_reg;

  assign o_engine_enable = ctrl_reg[0];

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ctrl_reg    <= '0;
      scratch_reg <= '0;
    end else if (i_cs && i_req.we) begin
      case (i_req.address)
        ADDR_CTRL:    ctrl_reg    <= i_req.write_data;
        ADDR_SCRATCH: scratch_reg <= i_req.write_data;
        default: ;
      endcase
    end
  end

  // Read word, only while selected
  always_comb begin
    o_read_data = '0;
    if (i_cs) begin
      case (i_req.address)
        ADDR_NAME0:   o_read_data = ENGINE_NAME0;
        ADDR_NAME1:   o_read_data = ENGINE_NAME1;
        ADDR_VERSION: o_read_data = ENGINE_VERSION;
        ADDR_CTRL:    o_read_data = ctrl_reg;
        ADDR_SCRATCH: o_read_data = scratch_reg;
        default:      o_read_data = '0;
      endcase
    end
  end

endmodule

//--- hdl/nts_keymem.sv
/*
 * Key memory. Four 256-bit keys as eight words each, a 32-bit id per
 * key, and a control word with valid bits and the current-key index.
 */

module nts_keymem (
  input  logic                   i_clk,
  input  logic                   i_areset,
  input  logic                   i_cs,
  input  nts_api_pkg::int_req_t  i_req,
  output nts_api_pkg::api_data_t o_read_data,
  output logic                   o_key_valid,
  output nts_api_pkg::key_id_t   o_key_id
);

  import nts_api_pkg::*;

  //--------------------------------------------------------------------
  // Register map
  //--------------------------------------------------------------------

  // 00..1F key words, key k at 8k..8k+7
  // 20..23 key ids
  localparam int_addr_t ADDR_CTRL = 8'h24;

  api_data_t   key_mem [32];
  key_id_t     key_id_reg [4];
  logic [3:0]  key_valid_reg;
  logic [1:0]  current_key_reg;
  logic        wr;
  logic        is_key_word;
  logic        is_key_id;

  assign wr          = i_cs && i_req.we;
  assign is_key_word = (i_req.address[7:5] == 3'b000);
  assign is_key_id   = (i_req.address[7:2] == 6'b001000);

  // Selected key, seen by the engine core
  assign o_key_id    = key_id_reg[current_key_reg];
  assign o_key_valid = key_valid_reg[current_key_reg];

  // Key storage
  always_ff @(posedge i_clk) begin
    if (wr && is_key_word) begin
      key_mem[i_req.address[4:0]] <= i_req.write_data;
    end
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      key_id_reg      <= '{default: '0};
      key_valid_reg   <= '0;
      current_key_reg <= '0;
    end else if (wr) begin
      if (is_key_id) begin
        key_id_reg[i_req.address[1:0]] <= i_req.write_data;
      end
      if (i_req.address == ADDR_CTRL) begin
        key_valid_reg   <= i_req.write_data[3:0];
        current_key_reg <= i_req.write_data[5:4];
      end
    end
  end

  always_comb begin
    o_read_data = '0;
    if (i_cs) begin
      if (is_key_word) begin
        o_read_data = key_mem[i_req.address[4:0]];
      end else if (is_key_id) begin
        o_read_data = key_id_reg[i_req.address[1:0]];
      end else if (i_req.address == ADDR_CTRL) begin
        o_read_data = {26'd0, current_key_reg, key_valid_reg};
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the NTS register front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module nts_api_tb -Mdir obj_dir -o nts_api_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/nts_api_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

//--- sim/nts_api_tb_tasks.svh
/*
 * Host bus tasks, key data generator and expected-value model for the
 * NTS register front end testbench. Included inside the testbench top.
 */

`ifndef NTS_API_TB_TASKS_SVH
`define NTS_API_TB_TASKS_SVH

// Expected state of every endpoint register
api_data_t   m_ctrl;
api_data_t   m_scratch;
logic        m_run;
api_data_t   m_load_hi;
api_data_t   m_load_lo;
logic [63:0] m_count_base;
int          m_count_cycle;
logic [63:0] m_snapshot;
api_data_t   m_key_word [32];
key_id_t     m_key_id [4];
api_data_t   m_key_ctrl;

// LCG step for key data
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic model_reset();
  m_ctrl        = '0;
  m_scratch     = '0;
  m_run         = 1'b0;
  m_load_hi     = '0;
  m_load_lo     = '0;
  m_count_base  = '0;
  m_count_cycle = 0;
  m_snapshot    = '0;
  m_key_word    = '{default: '0};
  m_key_id      = '{default: '0};
  m_key_ctrl    = '0;
endtask

// Counter value just before the write edge of a request issued at cycle c
function automatic logic [63:0] count_at(input int c);
  if (m_run) begin
    return m_count_base + 64'(c - m_count_cycle - 1);
  end
  return m_count_base;
endfunction

//----------------------------------------------------------------------
// Register map model
//----------------------------------------------------------------------

task automatic model_write(input api_addr_t addr, input api_data_t data);
  logic [63:0] now;
  now = count_at(cycle);
  case (addr)
    12'h008: m_ctrl = data;
    12'h009: m_scratch = data;
    12'h010: begin
      // Run change, counter still steps on this edge if it was running
      m_count_base  = now + (m_run ? 64'd1 : 64'd0);
      m_count_cycle = cycle;
      m_run         = data[0];
    end
    12'h011: m_load_hi = data;
    12'h012: m_load_lo = data;
    12'h013: begin
      m_count_base  = {m_load_hi, m_load_lo};
      m_count_cycle = cycle;
    end
    12'h014: m_snapshot = now;
    12'h0a4: m_key_ctrl = {26'd0, data[5:0]};
    default: begin
      if (addr >= 12'h080 && addr <= 12'h09f) begin
        m_key_word[addr[4:0]] = data;
      end
      if (addr >= 12'h0a0 && addr <= 12'h0a3) begin
        m_key_id[addr[1:0]] = data;
      end
    end
  endcase
endtask

function automatic api_data_t model_read(input api_addr_t addr);
  case (addr)
    12'h000: return ENGINE_NAME0;
    12'h001: return ENGINE_NAME1;
    12'h002: return ENGINE_VERSION;
    12'h008: return m_ctrl;
    12'h009: return m_scratch;
    12'h010: return {31'd0, m_run};
    12'h011: return m_load_hi;
    12'h012: return m_load_lo;
    12'h015: return m_snapshot[63:32];
    12'h016: return m_snapshot[31:0];
    12'h0a4: return m_key_ctrl;
    default: ;
  endcase
  if (addr >= 12'h080 && addr <= 12'h09f) begin
    return m_key_word[addr[4:0]];
  end
  if (addr >= 12'h0a0 && addr <= 12'h0a3) begin
    return m_key_id[addr[1:0]];
  end
  // Unmapped and unused offsets
  return 32'd0;
endfunction

//----------------------------------------------------------------------
// Host bus
//----------------------------------------------------------------------

// One strobe per call, starting and ending on a falling edge
task automatic bus_request(input logic we, input api_addr_t addr, input api_data_t data);
  i_api_cs  = 1'b1;
  i_api_req = '{we: we, address: addr, write_data: data};
  if (we) begin
    model_write(addr, data);
    exp_q.push_back(32'd0);
  end else begin
    exp_q.push_back(model_read(addr));
  end
  name_q.push_back(test_name);
  req_count++;
  @(negedge i_clk);
  i_api_cs = 1'b0;
endtask

task automatic bus_write(input api_addr_t addr, input api_data_t data);
  bus_request(1'b1, addr, data);
endtask

task automatic bus_read(input api_addr_t addr);
  bus_request(1'b0, addr, 32'd0);
endtask

task automatic idle(input int n);
  repeat (n) @(negedge i_clk);
endtask

// Wait until every issued request has answered
task automatic drain();
  while (resp_count != req_count) begin
    @(posedge i_clk);
  end
  @(negedge i_clk);
endtask

task automatic check_value(input string what, input api_data_t exp, input api_data_t act);
  assert (act == exp) else begin
    errors++;
    $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

`endif

//--- sim/nts_api_tb.sv
/*
 * Testbench for the NTS register front end. Drives host requests,
 * checks every response against the register model and the pipeline
 * timing of the valid strobe.
 */

module nts_api_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import nts_api_pkg::*;

  // Idle gap between the two running snapshots
  localparam int CLOCK_IDLE = 5;
  // Roughly 200 cycles of requests and drains plus ample margin
  localparam int MAX_CYCLES = 600;

  logic      i_clk;
  logic      i_areset;
  logic      i_api_cs;
  ext_req_t  i_api_req;
  logic      o_busy;
  api_data_t o_api_read_data;
  logic      o_api_read_data_valid;
  logic      o_engine_enable;
  logic      o_key_valid;
  key_id_t   o_key_id;

  int          cycle = 0;
  int          errors = 0;
  int          req_count = 0;
  int          resp_count = 0;
  logic [31:0] lcg_state;
  string       test_name;
  // Expected responses in request order
  api_data_t   exp_q [$];
  string       name_q [$];

  `include "nts_api_tb_tasks.svh"

  nts_api_top dut0 (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_api_cs              (i_api_cs),
    .i_api_req             (i_api_req),
    .o_busy                (o_busy),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid),
    .o_engine_enable       (o_engine_enable),
    .o_key_valid           (o_key_valid),
    .o_key_id              (o_key_id)
  );

  always #50 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  //----------------------------------------------------------------------
  // Response checks
  //----------------------------------------------------------------------

  // Response word against the oldest expected word
  always @(negedge i_clk) begin : response_check
    api_data_t exp_word;
    string     name;
    if (o_api_read_data_valid) begin
      resp_count++;
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        name     = name_q.pop_front();
        assert (o_api_read_data == exp_word) else begin
          errors++;
          $display("Fail %s expected %h actual %h", name, exp_word, o_api_read_data);
        end
      end
    end
  end

  // Valid register loads on edge 3 and is sampled on the next edge
  assert property (@(posedge i_clk) disable iff (i_areset)
    o_api_read_data_valid == $past(i_api_cs, 4))
  else begin
    errors++;
    $display("Response valid pulse out of step with its request at cycle %0d", cycle);
  end

  // No response without a request waiting for it
  assert property (@(posedge i_clk) disable iff (i_areset)
    o_api_read_data_valid |-> resp_count <= req_count)
  else begin
    errors++;
    $display("Response valid pulse with no request outstanding at cycle %0d", cycle);
  end

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------

  initial begin : stimulus
    i_clk     = 1'b0;
    i_areset  = 1'b1;
    i_api_cs  = 1'b0;
    i_api_req = '0;
    lcg_state = 32'd70;
    test_name = "reset";
    model_reset();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_areset = 1'b0;

    // Flags low and identity words
    check_value("busy", 32'd0, 32'(o_busy));
    check_value("valid", 32'd0, 32'(o_api_read_data_valid));
    check_value("engine_enable", 32'd0, 32'(o_engine_enable));
    check_value("key_valid", 32'd0, 32'(o_key_valid));
    bus_read(12'h000);
    bus_read(12'h001);
    bus_read(12'h002);
    drain();

    // Enable follows control bit 0 after scratch and control writes
    test_name = "engine";
    bus_write(12'h009, 32'hdead_beef);
    bus_write(12'h008, 32'h0000_0001);
    bus_read(12'h009);
    bus_read(12'h008);
    drain();
    check_value("engine_enable", 32'd1, 32'(o_engine_enable));
    bus_write(12'h008, 32'h0000_0002);
    bus_read(12'h008);
    drain();
    check_value("engine_enable", 32'd0, 32'(o_engine_enable));

    // Snapshot of the stopped counter equals the loaded value
    test_name = "clock";
    bus_write(12'h011, 32'h0000_0001);
    bus_write(12'h012, 32'hffff_fffc);
    bus_write(12'h013, 32'd0);
    idle(3);
    bus_write(12'h014, 32'd0);
    bus_read(12'h015);
    bus_read(12'h016);
    drain();
    // Low word of the running counter wraps between the two latches
    bus_write(12'h010, 32'd1);
    bus_write(12'h014, 32'd0);
    bus_read(12'h015);
    bus_read(12'h016);
    idle(CLOCK_IDLE);
    bus_write(12'h014, 32'd0);
    bus_read(12'h015);
    bus_read(12'h016);
    bus_write(12'h010, 32'd0);
    bus_read(12'h010);
    drain();

    // Fill all key words and ids and select key 2 as valid
    test_name = "keymem";
    for (int i = 0; i < 36; i++) begin
      lcg_state = lcg_next(lcg_state);
      bus_write(12'h080 + 12'(i), lcg_state);
    end
    for (int i = 0; i < 36; i++) begin
      bus_read(12'h080 + 12'(i));
    end
    bus_write(12'h0a4, 32'h0000_0024);
    bus_read(12'h0a4);
    drain();
    check_value("key_valid", 32'd1, 32'(o_key_valid));
    check_value("key_id", m_key_id[2], o_key_id);

    // Holes and addresses beyond every region
    test_name = "unmapped";
    bus_write(12'h009, 32'h5a5a_0f0f);
    bus_read(12'h040);
    bus_read(12'h3f0);
    bus_write(12'h040, 32'hffff_ffff);
    // Low byte matches the scratch offset, only the upper bits keep it out
    bus_write(12'h309, 32'hffff_ffff);
    bus_write(12'h00a, 32'hffff_ffff);
    bus_read(12'h009);
    bus_read(12'h0a5);
    drain();

    // Back to back reads across all regions
    test_name = "burst";
    bus_read(12'h000);
    bus_read(12'h015);
    bus_read(12'h085);
    bus_read(12'h0a1);
    bus_read(12'h009);
    bus_read(12'h040);
    bus_read(12'h0a4);
    bus_read(12'h002);
    drain();

    // Busy is set by an isolated strobe and cleared at stage 2
    test_name = "busy";
    bus_read(12'h001);
    check_value("busy", 32'd1, 32'(o_busy));
    drain();
    check_value("busy", 32'd0, 32'(o_busy));

    $display("Errors: %0d, responses: %0d of %0d requests", errors, resp_count, req_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+sim
hdl/nts_api_pkg.sv
hdl/nts_api.sv
hdl/nts_engine_regs.sv
hdl/nts_clock_regs.sv
hdl/nts_keymem.sv
hdl/nts_api_top.sv
sim/nts_api_tb.sv
